/* src.f */
+incdir+hw
hw/sf_pkg.sv
hw/sf_start_tracker.sv
hw/sf_mispred_tracker.sv
hw/sf_ld_match.sv
hw/lsu_spec_fail_predict_top.sv
bench/sf_assert.sv
bench/sf_tb.sv

/* Makefile */
# Verilator build, run, lint and clean for the spec-fail predictor

OBJ = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module sf_tb -f src.f --Mdir $(OBJ) -o sf_sim

run: build
	./$(OBJ)/sf_sim | tee /dev/stderr | grep -q "All tests passed!"

lint:
	verilator --lint-only -Wall --top-module lsu_spec_fail_predict_top +incdir+hw \
	  hw/sf_pkg.sv hw/sf_start_tracker.sv hw/sf_mispred_tracker.sv \
	  hw/sf_ld_match.sv hw/lsu_spec_fail_predict_top.sv

clean:
	rm -rf $(OBJ)

/* bench/sf_stim.txt */
# hex columns: st_addr st_iid st_bytes no_spec_miss spec_chk ld_vld ld_addr ld_bytes
# flush sf_flush sf_iid exp_mark exp_hit, one line per cycle
00000000 00 0000 0 0 1 00001000 ffff 0 0 00 0 0
00001000 05 000f 1 0 0 00000000 0000 0 0 00 0 0
00000000 00 0000 0 0 0 00000000 0000 1 1 05 0 0
00000000 00 0000 0 0 1 00001000 00f0 0 0 00 0 0
00000000 00 0000 0 0 0 00001000 0001 0 0 00 1 0
00000000 00 0000 0 0 1 00001000 0003 0 0 00 1 0
00000000 00 0000 0 0 1 00001000 0003 0 0 00 0 0
00002000 10 00f0 0 1 0 00000000 0000 0 0 00 0 0
00000000 00 0000 0 0 1 00002000 0010 0 0 00 0 1
00000000 00 0000 0 0 1 00002000 0010 0 0 00 0 0
00002000 20 00f0 0 1 0 00000000 0000 0 0 00 0 0
00003000 30 ff00 0 1 0 00000000 0000 0 0 00 0 0
00000000 00 0000 0 0 1 00003000 ff00 0 0 00 0 0
00003000 18 ff00 0 1 0 00000000 0000 0 0 00 0 0
00000000 00 0000 0 0 1 00003000 0100 0 0 00 0 1
00000000 00 0000 0 0 1 00002000 00f0 0 0 00 0 0
00001000 07 00ff 1 0 0 00000000 0000 0 0 00 0 0
00000000 00 0000 0 0 0 00000000 0000 1 1 07 0 0
00000000 00 0000 0 0 1 00002000 00ff 0 0 00 0 0
00000000 00 0000 0 0 1 00002000 00ff 0 0 00 0 0
00000000 00 0000 0 0 1 00002000 00ff 0 0 00 0 0
00000000 00 0000 0 0 1 00002000 00ff 0 0 00 0 0
00000000 00 0000 0 0 1 00002000 00ff 0 0 00 0 0
00000000 00 0000 0 0 1 00002000 00ff 0 0 00 0 0
00000000 00 0000 0 0 1 00002000 00ff 0 0 00 0 0
00000000 00 0000 0 0 1 00002000 00ff 0 0 00 0 0
00000000 00 0000 0 0 1 00002000 00ff 0 0 00 0 0
00000000 00 0000 0 0 1 00002000 00ff 0 0 00 0 0
00000000 00 0000 0 0 1 00002000 00ff 0 0 00 0 0
00000000 00 0000 0 0 0 00001000 0001 0 0 00 1 0
00000000 00 0000 0 0 1 00002000 00ff 0 0 00 0 0
00000000 00 0000 0 0 1 00001000 00ff 0 0 00 0 0
00001000 09 000f 1 1 0 00000000 0000 0 0 00 0 0
00000000 00 0000 0 0 0 00000000 0000 1 1 09 0 0
00002000 0a 00ff 0 1 0 00000000 0000 0 0 00 0 0
00000000 00 0000 0 0 0 00002000 0001 0 0 00 0 1
00000000 00 0000 0 0 0 00001000 0001 0 0 00 1 0
00000000 00 0000 0 0 0 00000000 0000 1 0 00 0 0
00000000 00 0000 0 0 1 00001000 000f 0 0 00 0 0
00000000 00 0000 0 0 1 00002000 00ff 0 0 00 0 0

/* bench/sf_tb.sv */
/*
 * testbench for the spec-fail predictor
 * clock and reset, line-per-cycle stimulus player,
 * compare of both output flags every cycle
 */

`default_nettype none

`include "sf_defines.svh"

module sf_tb;

  // upper bound on stimulus lines for the read loop
  localparam int max_lines = 64;

  logic               sf_clk;
  logic               cpurst_b;
  sf_pkg::sf_st_evt_t st_evt;
  sf_pkg::sf_ld_req_t ld_req;
  sf_pkg::sf_rtu_t    rtu;
  logic               sf_spec_mark;
  logic               sf_spec_hit;

  int                 stim_fd;
  int                 line_cnt;

  //==========================================================================
  // DUT and clock
  //==========================================================================
  lsu_spec_fail_predict_top u_lsu_spec_fail_predict_top (
    .sf_clk       (sf_clk),
    .cpurst_b     (cpurst_b),
    .st_evt       (st_evt),
    .ld_req       (ld_req),
    .rtu          (rtu),
    .sf_spec_mark (sf_spec_mark),
    .sf_spec_hit  (sf_spec_hit)
  );

  initial
  begin
    sf_clk = 1'b0;
    forever #5 sf_clk = ~sf_clk;
  end

  //==========================================================================
  // compare and stimulus player
  //==========================================================================
  task automatic check_equal(input logic actual, input logic expected, input string what);
    if (actual !== expected)
    begin
      $display("mismatch at time %0t: %s is %0b, expected %0b (stimulus line %0d)",
               $time, what, actual, expected, line_cnt);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // one data line driven on the falling edge
  task automatic play_line(input string text);
    int                     n_fields;
    logic [`SF_ADDR_W-1:0]  st_addr;
    logic [`SF_IID_W-1:0]   st_iid;
    logic [`SF_BYTES_W-1:0] st_bytes;
    logic                   st_nsm;
    logic                   st_chk;
    logic                   ld_vld;
    logic [`SF_ADDR_W-1:0]  ld_addr;
    logic [`SF_BYTES_W-1:0] ld_bytes;
    logic                   flush;
    logic                   sf_flush;
    logic [`SF_IID_W-1:0]   sf_iid;
    logic                   exp_mark;
    logic                   exp_hit;
    n_fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                       st_addr, st_iid, st_bytes, st_nsm, st_chk,
                       ld_vld, ld_addr, ld_bytes, flush, sf_flush, sf_iid,
                       exp_mark, exp_hit);
    if (n_fields != 13)
    begin
      $display("stimulus line %0d is malformed, %0d of 13 fields read", line_cnt, n_fields);
      $display("Test failures found");
      $fatal(1, "bad stimulus line");
    end
    else
    begin
      @(negedge sf_clk);
      st_evt.info.addr  = st_addr;
      st_evt.info.iid   = st_iid;
      st_evt.info.bytes = st_bytes;
      st_evt.no_spec_miss = st_nsm;
      st_evt.spec_chk   = st_chk;
      ld_req.vld        = ld_vld;
      ld_req.addr       = ld_addr;
      ld_req.bytes      = ld_bytes;
      rtu.flush         = flush;
      rtu.sf_flush      = sf_flush;
      rtu.sf_iid        = sf_iid;
      // flags are combinational and settle before the rising edge
      #2;
      check_equal(sf_spec_mark, exp_mark, "sf_spec_mark");
      check_equal(sf_spec_hit, exp_hit, "sf_spec_hit");
    end
  endtask

  // read loop skips comment lines and ends with the verdict
  task automatic run_stimulus();
    string text;
    int    n_read;
    bit    stim_done;
    bit    timed_out;
    stim_done = 1'b0;
    timed_out = 1'b0;
    while (!stim_done && !timed_out)
    begin
      n_read = $fgets(text, stim_fd);
      if (n_read == 0)
        stim_done = 1'b1;
      else if (line_cnt >= max_lines)
        timed_out = 1'b1;
      else
      begin
        line_cnt = line_cnt + 1;
        if (text.len() > 1 && text.getc(0) != "#")
          play_line(text);
      end
    end
    $fclose(stim_fd);
    if (timed_out)
    begin
      $display("stimulus file exceeds %0d lines, read loop timed out", max_lines);
      $display("Test failures found");
      $fatal(1, "stimulus read timeout");
    end
    else if (u_lsu_spec_fail_predict_top.u_sf_assert.fail_cnt != 0)
    begin
      $display("%0d bound assertion checks failed",
               u_lsu_spec_fail_predict_top.u_sf_assert.fail_cnt);
      $display("Test failures found");
      $fatal(1, "assertion failures");
    end
    else
    begin
      $display("All tests passed!");
      $finish;
    end
  endtask

  //==========================================================================
  // main sequence
  //==========================================================================
  initial
  begin
    st_evt   = '0;
    ld_req   = '0;
    rtu      = '0;
    cpurst_b = 1'b0;
    line_cnt = 0;
    // reset held for 2 cycles
    repeat (2) @(posedge sf_clk);
    @(negedge sf_clk);
    cpurst_b = 1'b1;
    stim_fd = $fopen("bench/sf_stim.txt", "r");
    if (stim_fd == 0)
    begin
      $display("could not open the stimulus file bench/sf_stim.txt");
      $display("Test failures found");
      $fatal(1, "missing stimulus file");
    end
    else
      run_stimulus();
  end

endmodule

`default_nettype wire

/* bench/sf_assert.sv */
/*
 * bound checks on the predictor top level
 * flags after a consume, flush clearing, arm sequencing
 */

`default_nettype none

module sf_assert (
  input logic              sf_clk,
  input logic              cpurst_b,
  input sf_pkg::sf_rtu_t   rtu,
  input sf_pkg::sf_entry_t start_entry,
  input sf_pkg::sf_entry_t chk_entry,
  input logic              sf_spec_mark,
  input logic              sf_spec_hit,
  input logic              mark_clr,
  input logic              hit_clr,
  input logic              pre_vld,
  input logic              armed,
  input logic              arm,
  input logic              chk_cap
);

  // failed assertions so far
  int fail_cnt = 0;

  // consumed entry is gone, no flag from it in the next cycle
  a_mark_used: assert property (@(posedge sf_clk) disable iff (!cpurst_b)
    (mark_clr && !arm) |=> !sf_spec_mark)
    else
    begin
      fail_cnt = fail_cnt + 1;
      $error("sf_spec_mark high after the start entry was consumed");
    end

  // a capture in the same cycle keeps the check entry alive
  a_hit_used: assert property (@(posedge sf_clk) disable iff (!cpurst_b)
    (hit_clr && !chk_cap) |=> !sf_spec_hit)
    else
    begin
      fail_cnt = fail_cnt + 1;
      $error("sf_spec_hit high after the check entry was consumed");
    end

  // plain flush empties both trackers
  a_flush_clr: assert property (@(posedge sf_clk) disable iff (!cpurst_b)
    (rtu.flush && !arm) |=> (!start_entry.vld && !chk_entry.vld))
    else
    begin
      fail_cnt = fail_cnt + 1;
      $error("entry still valid after a flush that did not arm");
    end

  // armed only via pre-valid
  a_arm_seq: assert property (@(posedge sf_clk) disable iff (!cpurst_b)
    $rose(armed) |-> $past(pre_vld))
    else
    begin
      fail_cnt = fail_cnt + 1;
      $error("start entry armed without pre-valid");
    end

endmodule

bind lsu_spec_fail_predict_top sf_assert u_sf_assert (
  .sf_clk       (sf_clk),
  .cpurst_b     (cpurst_b),
  .rtu          (rtu),
  .start_entry  (start_entry),
  .chk_entry    (chk_entry),
  .sf_spec_mark (sf_spec_mark),
  .sf_spec_hit  (sf_spec_hit),
  .mark_clr     (mark_clr),
  .hit_clr      (hit_clr),
  .pre_vld      (u_start.pre_vld),
  .armed        (u_start.armed),
  .arm          (u_start.arm),
  .chk_cap      (u_mispred.info_up)
);

`default_nettype wire

/* hw/lsu_spec_fail_predict_top.sv */
/*
 * store-to-load spec-fail predictor, top level
 * start tracker, misprediction tracker and load matcher
 */

`default_nettype none

module lsu_spec_fail_predict_top (
  input  logic               sf_clk,
  input  logic               cpurst_b,
  input  sf_pkg::sf_st_evt_t st_evt,
  input  sf_pkg::sf_ld_req_t ld_req,
  input  sf_pkg::sf_rtu_t    rtu,
  output logic               sf_spec_mark,
  output logic               sf_spec_hit
);

  // entries towards the matcher
  sf_pkg::sf_entry_t start_entry;
  sf_pkg::sf_entry_t chk_entry;

  // consume pulses back to the trackers
  logic              mark_clr;
  logic              hit_clr;

  //==========================================================================
  // trackers
  //==========================================================================
  sf_start_tracker u_start (
    .sf_clk      (sf_clk),
    .cpurst_b    (cpurst_b),
    .st_evt      (st_evt),
    .rtu         (rtu),
    .ld_req_vld  (ld_req.vld),
    .mark_clr    (mark_clr),
    .start_entry (start_entry)
  );

  sf_mispred_tracker u_mispred (
    .sf_clk     (sf_clk),
    .cpurst_b   (cpurst_b),
    .st_evt     (st_evt),
    .rtu        (rtu),
    .ld_req_vld (ld_req.vld),
    .hit_clr    (hit_clr),
    .chk_entry  (chk_entry)
  );

  //==========================================================================
  // load matcher
  //==========================================================================
  sf_ld_match u_match (
    .ld_req       (ld_req),
    .start_entry  (start_entry),
    .chk_entry    (chk_entry),
    .sf_spec_mark (sf_spec_mark),
    .sf_spec_hit  (sf_spec_hit),
    .mark_clr     (mark_clr),
    .hit_clr      (hit_clr)
  );

endmodule

`default_nettype wire

/* hw/sf_ld_match.sv */
/*
 * load matcher
 * overlap compare of one load against both tracker entries,
 * external flags and consume pulses
 */

`default_nettype none

module sf_ld_match (
  input  sf_pkg::sf_ld_req_t ld_req,
  input  sf_pkg::sf_entry_t  start_entry,
  input  sf_pkg::sf_entry_t  chk_entry,
  output logic               sf_spec_mark,
  output logic               sf_spec_hit,
  output logic               mark_clr,
  output logic               hit_clr
);

  //==========================================================================
  // overlap compare
  //==========================================================================
  // same line and at least one common byte
  function automatic logic ld_overlap(input sf_pkg::sf_ld_req_t req,
                                      input sf_pkg::sf_entry_t  ent);
    logic addr_eq;
    logic bytes_any;
    addr_eq   = (req.addr == ent.info.addr);
    bytes_any = |(req.bytes & ent.info.bytes);
    return ent.vld && addr_eq && bytes_any;
  endfunction

  logic start_hit;
  logic chk_hit;

  assign start_hit = ld_overlap(ld_req, start_entry);
  assign chk_hit   = ld_overlap(ld_req, chk_entry);

  //==========================================================================
  // outputs
  //==========================================================================
  // flags do not wait for the request strobe
  assign sf_spec_mark = start_hit;
  assign sf_spec_hit  = chk_hit;

  // consume only on a real load request
  assign mark_clr     = start_hit && ld_req.vld;
  assign hit_clr      = chk_hit && ld_req.vld;

endmodule

`default_nettype wire

/* hw/sf_mispred_tracker.sv */
/*
 * misprediction-check tracker
 * keeps the oldest spec-check store, expires it after 12
 * unmatched loads or on a flush
 */

`default_nettype none

`include "sf_defines.svh"

module sf_mispred_tracker (
  input  logic               sf_clk,
  input  logic               cpurst_b,
  input  sf_pkg::sf_st_evt_t st_evt,
  input  sf_pkg::sf_rtu_t    rtu,
  input  logic               ld_req_vld,
  input  logic               hit_clr,
  output sf_pkg::sf_entry_t  chk_entry
);

  localparam logic [`SF_CLR_CNT_W-1:0] clr_max  = `SF_CLR_MAX;
  localparam logic [`SF_CLR_CNT_W-1:0] cnt_step = 1;

  logic                      vld;
  logic [`SF_CLR_CNT_W-1:0]  clr_cnt;
  sf_pkg::sf_st_info_t       st_info;

  logic                      older_st;
  logic                      info_up;
  logic                      cnt_max;

  //==========================================================================
  // control
  //==========================================================================
  // held store newer than incoming, so take the incoming one
  assign older_st = sf_pkg::iid_newer(st_info.iid, st_evt.info.iid);
  assign info_up  = st_evt.spec_chk && (!vld || older_st);

  assign cnt_max  = (clr_cnt == clr_max);

  //==========================================================================
  // state registers
  //==========================================================================
  // flush kills the entry, even against a capture in the same cycle
  always_ff @(posedge sf_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      vld <= 1'b0;
    else if (rtu.flush)
      vld <= 1'b0;
    else if (info_up)
      vld <= 1'b1;
    else if (hit_clr || cnt_max)
      vld <= 1'b0;
  end

  // restarts on every new capture
  always_ff @(posedge sf_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      clr_cnt <= '0;
    else if (info_up)
      clr_cnt <= '0;
    else if (vld && ld_req_vld)
      clr_cnt <= clr_cnt + cnt_step;
  end

  // store payload
  always_ff @(posedge sf_clk)
  begin
    if (info_up)
      st_info <= st_evt.info;
  end

  // hide the entry in its expiry cycle
  assign chk_entry.vld  = vld && !cnt_max;
  assign chk_entry.info = st_info;

endmodule

`default_nettype wire

/* hw/sf_start_tracker.sv */
/*
 * prediction-start tracker
 * holds the oldest no-spec-miss store, arms it on the spec-fail
 * flush of its own iid, drops it after 12 unmatched loads
 */

`default_nettype none

`include "sf_defines.svh"

module sf_start_tracker (
  input  logic               sf_clk,
  input  logic               cpurst_b,
  input  sf_pkg::sf_st_evt_t st_evt,
  input  sf_pkg::sf_rtu_t    rtu,
  input  logic               ld_req_vld,
  input  logic               mark_clr,
  output sf_pkg::sf_entry_t  start_entry
);

  localparam logic [`SF_CLR_CNT_W-1:0] clr_max  = `SF_CLR_MAX;
  localparam logic [`SF_CLR_CNT_W-1:0] cnt_step = 1;

  // two-stage state, pre-valid then armed
  logic                      pre_vld;
  logic                      armed;
  logic [`SF_CLR_CNT_W-1:0]  clr_cnt;
  sf_pkg::sf_st_info_t       st_info;

  logic                      older_st;
  logic                      info_up;
  logic                      iid_hit;
  logic                      arm;
  logic                      cnt_max;

  //==========================================================================
  // control
  //==========================================================================
  // incoming store older than the held one
  assign older_st = sf_pkg::iid_newer(st_info.iid, st_evt.info.iid);

  // replace only until armed
  assign info_up  = st_evt.no_spec_miss
                    && !armed
                    && (!pre_vld || older_st);

  // retire flushed on our store
  assign iid_hit  = (st_info.iid == rtu.sf_iid);
  assign arm      = pre_vld && iid_hit && rtu.sf_flush && rtu.flush;

  assign cnt_max  = (clr_cnt == clr_max);

  //==========================================================================
  // state registers
  //==========================================================================
  // any flush drops a not yet armed candidate
  always_ff @(posedge sf_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pre_vld <= 1'b0;
    else if (rtu.flush)
      pre_vld <= 1'b0;
    else if (info_up)
      pre_vld <= 1'b1;
  end

  // arm wins over every clear source
  always_ff @(posedge sf_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      armed <= 1'b0;
    else if (arm)
      armed <= 1'b1;
    else if (mark_clr || cnt_max || rtu.flush)
      armed <= 1'b0;
  end

  // unmatched load count while armed
  always_ff @(posedge sf_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      clr_cnt <= '0;
    else if (arm)
      clr_cnt <= '0;
    else if (armed && ld_req_vld)
      clr_cnt <= clr_cnt + cnt_step;
  end

  // store payload
  always_ff @(posedge sf_clk)
  begin
    if (info_up)
      st_info <= st_evt.info;
  end

  // entry stops matching once the limit is reached
  assign start_entry.vld  = armed && !cnt_max;
  assign start_entry.info = st_info;

endmodule

`default_nettype wire

/* hw/sf_pkg.sv */
/*
 * shared types for the spec-fail predictor
 * store, load, retire and entry structs
 * iid age compare with wrap bit
 */

`default_nettype none

`include "sf_defines.svh"

package sf_pkg;

  //========================================================================
  // event and entry structs
  //========================================================================
  // store identity, kept in both trackers
  typedef struct packed {
    logic [`SF_ADDR_W-1:0]  addr;
    logic [`SF_IID_W-1:0]   iid;
    logic [`SF_BYTES_W-1:0] bytes;
  } sf_st_info_t;

  // store leaving the data stage
  typedef struct packed {
    sf_st_info_t info;
    logic        no_spec_miss;  // candidate for prediction start
    logic        spec_chk;      // store asks for a spec check
  } sf_st_evt_t;

  // load check request from the data stage
  typedef struct packed {
    logic                   vld;
    logic [`SF_ADDR_W-1:0]  addr;
    logic [`SF_BYTES_W-1:0] bytes;
  } sf_ld_req_t;

  // retire unit flush info
  typedef struct packed {
    logic                 flush;     // general pipeline flush
    logic                 sf_flush;  // flush caused by spec fail
    logic [`SF_IID_W-1:0] sf_iid;
  } sf_rtu_t;

  // tracker entry as seen by the matcher
  typedef struct packed {
    logic        vld;
    sf_st_info_t info;
  } sf_entry_t;

  //========================================================================
  // iid age compare
  //========================================================================
  // true when a is newer than b
  // low bits compared, result flipped when wrap bits differ
  function automatic logic iid_newer(input logic [`SF_IID_W-1:0] a,
                                     input logic [`SF_IID_W-1:0] b);
    logic low_gt;
    logic wrap_diff;
    low_gt    = a[`SF_IID_W-2:0] > b[`SF_IID_W-2:0];
    wrap_diff = a[`SF_IID_W-1] ^ b[`SF_IID_W-1];
    return low_gt ^ wrap_diff;
  endfunction

endpackage

`default_nettype wire

/* hw/sf_defines.svh */
/*
 * width and limit macros for the store-to-load spec-fail predictor
 * address, iid and byte-mask widths plus the entry drop limit
 */

`ifndef SF_DEFINES_SVH
`define SF_DEFINES_SVH

//==========================================================================
// datapath widths
//==========================================================================
// line address, low 4 bits dropped
`define SF_ADDR_W 32
// instruction id, top bit is the wrap bit
`define SF_IID_W 7
// byte valid mask over a 16-byte line
`define SF_BYTES_W 16

//==========================================================================
// entry drop limit
//==========================================================================
// unmatched load requests before an entry is dropped
`define SF_CLR_MAX 12
`define SF_CLR_CNT_W 4

`endif
